// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  // free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // release on a falling edge after the last reset cycle
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== dv/threads_manager_sva.sv ====
`timescale 1ns/1ps

module threads_manager_sva #(
  parameter int PROC_QUANTITY = 8,
  localparam int CNT_W = $clog2(PROC_QUANTITY + 1)
) (
  input logic             clk,
  input logic             rst,
  input logic             cmd_valid_i,
  input logic             cmd_done_o,
  input logic             next_valid_o,
  input logic             stop_done_o,
  input logic [CNT_W-1:0] count_o
);

  // issue and removal share the id/addr outputs
  a_one_pulse: assert property (@(posedge clk) disable iff (rst)
    !(next_valid_o && stop_done_o))
    else $error("next_valid_o and stop_done_o high together");

  // response exactly one cycle after the strobe
  a_done_after_valid: assert property (@(posedge clk) disable iff (rst)
    cmd_valid_i |=> cmd_done_o)
    else $error("cmd_done_o missing after cmd_valid_i");

  a_no_stray_done: assert property (@(posedge clk) disable iff (rst)
    !cmd_valid_i |=> !cmd_done_o)
    else $error("cmd_done_o without cmd_valid_i");

  // table never overfilled
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count_o <= CNT_W'(PROC_QUANTITY))
    else $error("count_o above table depth");

endmodule

// ==== dv/threads_manager_tb.sv ====
`timescale 1ns/1ps

module threads_manager_tb import thrd_pkg::*; ();

  localparam int ID_W = 32;
  localparam int ADDR_W = 16;
  localparam int PQ = 8;
  localparam int CNT_W = $clog2(PQ + 1);
  localparam int TIMEOUT = 20;

  logic             clk;
  logic             rst;
  logic             cmd_valid;
  thrd_cmd_e        thrd_cmd;
  logic [ID_W-1:0]  thrd_id;
  logic [ADDR_W-1:0] thrd_addr;
  logic             next_thread;
  logic             cmd_done;
  logic             cmd_ok;
  logic             next_valid;
  logic             stop_done;
  logic [ID_W-1:0]  next_id;
  logic [ADDR_W-1:0] next_addr;
  logic [CNT_W-1:0] count;

  // reference model of table, scan index and slots
  logic [ID_W-1:0]   m_id [PQ];
  logic [ADDR_W-1:0] m_addr [PQ];
  int                m_cnt;
  int                m_scan;
  int                m_mark;
  logic              m_run_pend;
  logic [ID_W-1:0]   m_run_id;
  logic [ADDR_W-1:0] m_run_addr;
  logic              m_stop_pend;
  logic [ID_W-1:0]   m_stop_id;
  logic [ADDR_W-1:0] m_stop_addr;

  int errors;
  int timeouts;
  int checks;

  tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(16)) i_tb_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  threads_manager #(
    .ID_W          (ID_W),
    .ADDR_W        (ADDR_W),
    .PROC_QUANTITY (PQ)
  ) i_threads_manager (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid_i   (cmd_valid),
    .thrd_cmd_i    (thrd_cmd),
    .thrd_id_i     (thrd_id),
    .thrd_addr_i   (thrd_addr),
    .next_thread_i (next_thread),
    .cmd_done_o    (cmd_done),
    .cmd_ok_o      (cmd_ok),
    .next_valid_o  (next_valid),
    .stop_done_o   (stop_done),
    .next_id_o     (next_id),
    .next_addr_o   (next_addr),
    .count_o       (count)
  );

  // pulse and count rules on the top level ports
  bind threads_manager threads_manager_sva #(
    .PROC_QUANTITY (PROC_QUANTITY)
  ) i_threads_manager_sva (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_done_o   (cmd_done_o),
    .next_valid_o (next_valid_o),
    .stop_done_o  (stop_done_o),
    .count_o      (count_o)
  );

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // one command strobe, answer sampled one cycle later
  task automatic send_cmd(input thrd_cmd_e cmd, input logic [ID_W-1:0] id,
                          input logic [ADDR_W-1:0] addr);
    logic exp_ok;
    exp_ok = 1'b0;
    if (cmd == THRD_CMD_RUN && !m_run_pend) begin
      exp_ok = 1'b1;
      m_run_pend = 1'b1;
      m_run_id = id;
      m_run_addr = addr;
    end else if (cmd == THRD_CMD_STOP && !m_stop_pend) begin
      exp_ok = 1'b1;
      m_stop_pend = 1'b1;
      m_stop_id = id;
      m_stop_addr = addr;
      // lap starts where the scan stands now
      m_mark = m_scan;
    end
    @(negedge clk);
    cmd_valid = 1'b1;
    thrd_cmd = cmd;
    thrd_id = id;
    thrd_addr = addr;
    @(negedge clk);
    cmd_valid = 1'b0;
    thrd_cmd = THRD_CMD_NONE;
    compare_value("cmd_done_o", cmd_done, 1);
    compare_value("cmd_ok_o", cmd_ok, exp_ok);
  endtask

  task automatic send_random_run();
    send_cmd(THRD_CMD_RUN, $urandom(), ADDR_W'($urandom()));
  endtask

  // predict one schedule step, strobe, then wait for the pulse
  task automatic schedule();
    int kind;
    int last;
    int cycles;
    logic [ID_W-1:0] e_id;
    logic [ADDR_W-1:0] e_addr;
    kind = 0;
    e_id = '0;
    e_addr = '0;
    if (m_run_pend && m_cnt < PQ) begin
      // new thread goes to the table end
      kind = 1;
      e_id = m_run_id;
      e_addr = m_run_addr;
      m_id[m_cnt] = e_id;
      m_addr[m_cnt] = e_addr;
      m_cnt++;
      m_run_pend = 1'b0;
    end else if (m_cnt != 0) begin
      e_id = m_id[m_scan];
      e_addr = m_addr[m_scan];
      last = m_cnt - 1;
      if (m_stop_pend && e_id == m_stop_id && e_addr == m_stop_addr) begin
        // swap-remove, last entry fills the hole
        kind = 2;
        m_id[m_scan] = m_id[last];
        m_addr[m_scan] = m_addr[last];
        m_cnt--;
        if (m_scan >= m_cnt) m_scan = 0;
        m_stop_pend = 1'b0;
      end else begin
        kind = 1;
        m_scan = (m_scan == last) ? 0 : m_scan + 1;
        // back at the mark, stop given up
        if (m_stop_pend && m_scan == m_mark) m_stop_pend = 1'b0;
      end
    end
    @(negedge clk);
    next_thread = 1'b1;
    @(negedge clk);
    next_thread = 1'b0;
    cycles = 0;
    while (!next_valid && !stop_done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (kind == 0 && cycles < TIMEOUT) begin
      errors++;
      $display("%0t a pulse came from a schedule on an empty table", $time);
    end else if (kind != 0 && cycles >= TIMEOUT) begin
      timeouts++;
      $display("%0t timed out waiting for next_valid_o or stop_done_o", $time);
    end else if (kind != 0) begin
      compare_value("next_valid_o", next_valid, kind == 1);
      compare_value("stop_done_o", stop_done, kind == 2);
      compare_value("next_id_o", next_id, e_id);
      compare_value("next_addr_o", next_addr, e_addr);
    end
    compare_value("count_o", count, m_cnt);
  endtask

  task automatic check_reset_state();
    compare_value("cmd_done_o", cmd_done, 0);
    compare_value("cmd_ok_o", cmd_ok, 0);
    compare_value("next_valid_o", next_valid, 0);
    compare_value("stop_done_o", stop_done, 0);
    compare_value("count_o", count, 0);
    schedule();
  endtask

  // second run rejected while the slot is full
  task automatic run_single_thread();
    send_random_run();
    send_random_run();
    schedule();
  endtask

  task automatic rotate_round_robin();
    while (m_cnt < PQ - 2) begin
      send_random_run();
      schedule();
    end
    repeat (2 * m_cnt + 1) schedule();
  endtask

  task automatic remove_active_thread();
    int idx;
    idx = $urandom() % m_cnt;
    send_cmd(THRD_CMD_STOP, m_id[idx], m_addr[idx]);
    repeat (m_cnt + 1) schedule();
    repeat (2 * m_cnt) schedule();
  endtask

  // lap without a match frees the stop slot, and not earlier
  task automatic give_up_absent_stop();
    send_cmd(THRD_CMD_STOP, $urandom(), ADDR_W'($urandom()));
    repeat (m_cnt - 1) schedule();
    // one entry of the lap still unchecked, slot stays full
    send_cmd(THRD_CMD_STOP, $urandom(), ADDR_W'($urandom()));
    schedule();
    send_cmd(THRD_CMD_STOP, $urandom(), ADDR_W'($urandom()));
    repeat (m_cnt) schedule();
  endtask

  // parked run waits until a removal frees an entry
  task automatic park_run_when_full();
    while (m_cnt < PQ) begin
      send_random_run();
      schedule();
    end
    send_random_run();
    repeat (3) schedule();
    send_cmd(THRD_CMD_STOP, m_id[0], m_addr[0]);
    repeat (m_cnt + 2) schedule();
    repeat (PQ) schedule();
  endtask

  initial begin
    int n;
    cmd_valid = 1'b0;
    thrd_cmd = THRD_CMD_NONE;
    thrd_id = '0;
    thrd_addr = '0;
    next_thread = 1'b0;
    m_cnt = 0;
    m_scan = 0;
    m_mark = 0;
    m_run_pend = 1'b0;
    m_stop_pend = 1'b0;
    errors = 0;
    timeouts = 0;
    checks = 0;
    void'($urandom(39));
    n = 0;
    while (rst !== 1'b0 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (n >= 100) begin
      timeouts++;
      $display("%0t reset never released", $time);
    end
    check_reset_state();
    run_single_thread();
    rotate_round_robin();
    remove_active_thread();
    give_up_absent_stop();
    park_run_when_full();
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== source/thrd_cmd_slots.sv ====
`timescale 1ns/1ps

module thrd_cmd_slots import thrd_pkg::*; #(
  parameter int ID_W = 32,
  parameter int ADDR_W = 16,
  parameter int PROC_QUANTITY = 8,
  localparam int IDX_W = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1
) (
  input  logic              clk,
  input  logic              rst,
  // command side
  input  logic              cmd_valid_i,
  input  thrd_cmd_e         thrd_cmd_i,
  input  logic [ID_W-1:0]   thrd_id_i,
  input  logic [ADDR_W-1:0] thrd_addr_i,
  // scheduler side
  input  logic              run_taken_i,
  input  logic              stop_clear_i,
  input  logic [IDX_W-1:0]  scan_idx_i,
  output logic              run_pend_o,
  output logic [ID_W-1:0]   run_id_o,
  output logic [ADDR_W-1:0] run_addr_o,
  output logic              stop_pend_o,
  output logic [ID_W-1:0]   stop_id_o,
  output logic [ADDR_W-1:0] stop_addr_o,
  output logic [IDX_W-1:0]  stop_mark_o,
  // response, one cycle after the strobe
  output logic              cmd_done_o,
  output logic              cmd_ok_o
);

  logic run_acc;
  logic stop_acc;

  // a slot takes a command only when it is empty
  assign run_acc  = cmd_valid_i && (thrd_cmd_i == THRD_CMD_RUN) && !run_pend_o;
  assign stop_acc = cmd_valid_i && (thrd_cmd_i == THRD_CMD_STOP) && !stop_pend_o;

  // slot flags and response
  always_ff @(posedge clk) begin
    if (rst) begin
      run_pend_o  <= 1'b0;
      stop_pend_o <= 1'b0;
      cmd_done_o  <= 1'b0;
      cmd_ok_o    <= 1'b0;
    end else begin
      // every strobe answered, NONE gives ok low
      cmd_done_o <= cmd_valid_i;
      cmd_ok_o   <= run_acc || stop_acc;

      // clears only come while a slot is full, so no clash with accept
      if (run_taken_i) begin
        run_pend_o <= 1'b0;
      end else if (run_acc) begin
        run_pend_o <= 1'b1;
      end

      if (stop_clear_i) begin
        stop_pend_o <= 1'b0;
      end else if (stop_acc) begin
        stop_pend_o <= 1'b1;
      end
    end
  end

  // slot payload
  always_ff @(posedge clk) begin
    if (run_acc) begin
      run_id_o   <= thrd_id_i;
      run_addr_o <= thrd_addr_i;
    end
    if (stop_acc) begin
      stop_id_o   <= thrd_id_i;
      stop_addr_o <= thrd_addr_i;
      // scan position at acceptance, end of the search lap
      stop_mark_o <= scan_idx_i;
    end
  end

endmodule

// ==== source/thrd_pkg.sv ====
package thrd_pkg;

  // command opcode, sampled together with cmd_valid_i
  typedef enum logic [1:0] {
    // no request, answered with ok low
    THRD_CMD_NONE = 2'd0,
    // park a thread in the run slot
    THRD_CMD_RUN  = 2'd1,
    // park a thread in the stop slot
    THRD_CMD_STOP = 2'd2
  } thrd_cmd_e;

  // scheduler FSM states
  typedef enum logic [2:0] {
    S_IDLE       = 3'd0,
    // pending run written at table end
    S_INSERT     = 3'd1,
    // table read in flight
    S_READ       = 3'd2,
    // read entry vs stop slot
    S_CHECK      = 3'd3,
    // fetch last entry for swap-remove
    S_MOVE_READ  = 3'd4,
    // last entry over the removed one
    S_MOVE_WRITE = 3'd5
  } sched_state_e;

endpackage

// ==== source/thrd_sched.sv ====
`timescale 1ns/1ps

module thrd_sched import thrd_pkg::*; #(
  parameter int ID_W = 32,
  parameter int ADDR_W = 16,
  parameter int PROC_QUANTITY = 8,
  localparam int IDX_W = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1,
  localparam int CNT_W = $clog2(PROC_QUANTITY + 1)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              next_thread_i,
  // slots
  input  logic              run_pend_i,
  input  logic [ID_W-1:0]   run_id_i,
  input  logic [ADDR_W-1:0] run_addr_i,
  input  logic              stop_pend_i,
  input  logic [ID_W-1:0]   stop_id_i,
  input  logic [ADDR_W-1:0] stop_addr_i,
  input  logic [IDX_W-1:0]  stop_mark_i,
  output logic              run_taken_o,
  output logic              stop_clear_o,
  output logic [IDX_W-1:0]  scan_idx_o,
  // table
  output logic [IDX_W-1:0]  tbl_rd_addr_o,
  input  logic [ID_W-1:0]   tbl_rd_id_i,
  input  logic [ADDR_W-1:0] tbl_rd_addr_data_i,
  output logic              tbl_wr_en_o,
  output logic [IDX_W-1:0]  tbl_wr_addr_o,
  output logic [ID_W-1:0]   tbl_wr_id_o,
  output logic [ADDR_W-1:0] tbl_wr_addr_data_o,
  // issue side
  output logic              next_valid_o,
  output logic              stop_done_o,
  output logic [ID_W-1:0]   next_id_o,
  output logic [ADDR_W-1:0] next_addr_o,
  output logic [CNT_W-1:0]  count_o
);

  sched_state_e state_q;
  logic [IDX_W-1:0] scan_idx_q;
  logic [CNT_W-1:0] count_q;
  // strobe seen while busy
  logic sched_req_q;

  logic serve;
  logic can_insert;
  logic [CNT_W-1:0] cnt_m1;
  logic [IDX_W-1:0] last_idx;
  logic scan_last;
  logic [IDX_W-1:0] scan_next;
  logic hit;
  logic lap_end;

  assign serve      = next_thread_i || sched_req_q;
  // a full table leaves the run parked
  assign can_insert = run_pend_i && (count_q < CNT_W'(PROC_QUANTITY));

  // index of the last active entry
  assign cnt_m1    = count_q - CNT_W'(1);
  assign last_idx  = cnt_m1[IDX_W-1:0];
  assign scan_last = (scan_idx_q == last_idx);
  // round-robin step modulo count
  assign scan_next = scan_last ? '0 : scan_idx_q + IDX_W'(1);

  // read entry matches the stop slot
  assign hit = stop_pend_i && ({tbl_rd_id_i, tbl_rd_addr_data_i} == {stop_id_i, stop_addr_i});
  // scan about to come back to where the stop was taken, lap done
  assign lap_end = stop_pend_i && (scan_next == stop_mark_i);

  assign run_taken_o = (state_q == S_INSERT);
  // slot emptied on removal or on a lap without a match
  assign stop_clear_o = ((state_q == S_CHECK) && (hit ? scan_last : lap_end)) ||
                        (state_q == S_MOVE_WRITE);

  // table ports
  assign tbl_rd_addr_o = (state_q == S_MOVE_READ) ? last_idx : scan_idx_q;
  assign tbl_wr_en_o   = (state_q == S_INSERT) || (state_q == S_MOVE_WRITE);
  assign tbl_wr_addr_o = (state_q == S_INSERT) ? count_q[IDX_W-1:0] : scan_idx_q;
  // move writes the last entry still held in the read register
  assign tbl_wr_id_o        = (state_q == S_INSERT) ? run_id_i : tbl_rd_id_i;
  assign tbl_wr_addr_data_o = (state_q == S_INSERT) ? run_addr_i : tbl_rd_addr_data_i;

  assign scan_idx_o = scan_idx_q;
  assign count_o    = count_q;

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= S_IDLE;
      scan_idx_q   <= '0;
      count_q      <= '0;
      sched_req_q  <= 1'b0;
      next_valid_o <= 1'b0;
      stop_done_o  <= 1'b0;
    end else begin
      next_valid_o <= 1'b0;
      stop_done_o  <= 1'b0;
      if (next_thread_i && (state_q != S_IDLE)) begin
        sched_req_q <= 1'b1;
      end

      case (state_q)
        S_IDLE: begin
          if (serve) begin
            sched_req_q <= 1'b0;
            // new thread first, else scan the table
            if (can_insert) begin
              state_q <= S_INSERT;
            end else if (count_q != '0) begin
              state_q <= S_READ;
            end
          end
        end
        S_INSERT: begin
          count_q      <= count_q + CNT_W'(1);
          next_valid_o <= 1'b1;
          state_q      <= S_IDLE;
        end
        S_READ: begin
          state_q <= S_CHECK;
        end
        S_CHECK: begin
          if (hit && scan_last) begin
            // removing the tail, no copy needed
            count_q     <= cnt_m1;
            scan_idx_q  <= '0;
            stop_done_o <= 1'b1;
            state_q     <= S_IDLE;
          end else if (hit) begin
            state_q <= S_MOVE_READ;
          end else begin
            next_valid_o <= 1'b1;
            scan_idx_q   <= scan_next;
            state_q      <= S_IDLE;
          end
        end
        S_MOVE_READ: begin
          state_q <= S_MOVE_WRITE;
        end
        S_MOVE_WRITE: begin
          // scan index stays, now points at the moved entry
          count_q     <= cnt_m1;
          stop_done_o <= 1'b1;
          state_q     <= S_IDLE;
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // issued or removed entry, valid with the pulses
  always_ff @(posedge clk) begin
    if (state_q == S_INSERT) begin
      next_id_o   <= run_id_i;
      next_addr_o <= run_addr_i;
    end else if (state_q == S_CHECK) begin
      next_id_o   <= tbl_rd_id_i;
      next_addr_o <= tbl_rd_addr_data_i;
    end
  end

endmodule

// ==== source/thrd_table.sv ====
`timescale 1ns/1ps

module thrd_table #(
  parameter int ID_W = 32,
  parameter int ADDR_W = 16,
  parameter int PROC_QUANTITY = 8,
  localparam int IDX_W = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1
) (
  input  logic              clk,
  // read port, data one cycle after address
  input  logic [IDX_W-1:0]  rd_addr_i,
  output logic [ID_W-1:0]   rd_id_o,
  output logic [ADDR_W-1:0] rd_addr_data_o,
  // write port
  input  logic              wr_en_i,
  input  logic [IDX_W-1:0]  wr_addr_i,
  input  logic [ID_W-1:0]   wr_id_i,
  input  logic [ADDR_W-1:0] wr_addr_data_i
);

  // entry is {id, start address}
  logic [ID_W+ADDR_W-1:0] mem [PROC_QUANTITY];

  // write
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= {wr_id_i, wr_addr_data_i};
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    {rd_id_o, rd_addr_data_o} <= mem[rd_addr_i];
  end

endmodule

// ==== source/threads_manager.sv ====
`timescale 1ns/1ps

module threads_manager import thrd_pkg::*; #(
  parameter int ID_W = 32,
  parameter int ADDR_W = 16,
  parameter int PROC_QUANTITY = 8,
  localparam int IDX_W = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1,
  localparam int CNT_W = $clog2(PROC_QUANTITY + 1)
) (
  input  logic              clk,
  input  logic              rst,
  // commands
  input  logic              cmd_valid_i,
  input  thrd_cmd_e         thrd_cmd_i,
  input  logic [ID_W-1:0]   thrd_id_i,
  input  logic [ADDR_W-1:0] thrd_addr_i,
  // schedule strobe
  input  logic              next_thread_i,
  output logic              cmd_done_o,
  output logic              cmd_ok_o,
  output logic              next_valid_o,
  output logic              stop_done_o,
  output logic [ID_W-1:0]   next_id_o,
  output logic [ADDR_W-1:0] next_addr_o,
  output logic [CNT_W-1:0]  count_o
);

  // slots to scheduler
  logic              run_pend;
  logic [ID_W-1:0]   run_id;
  logic [ADDR_W-1:0] run_addr;
  logic              stop_pend;
  logic [ID_W-1:0]   stop_id;
  logic [ADDR_W-1:0] stop_addr;
  logic [IDX_W-1:0]  stop_mark;
  // scheduler to slots
  logic              run_taken;
  logic              stop_clear;
  logic [IDX_W-1:0]  scan_idx;
  // table port
  logic [IDX_W-1:0]  rd_addr;
  logic [ID_W-1:0]   rd_id;
  logic [ADDR_W-1:0] rd_addr_data;
  logic              wr_en;
  logic [IDX_W-1:0]  wr_addr;
  logic [ID_W-1:0]   wr_id;
  logic [ADDR_W-1:0] wr_addr_data;

  thrd_cmd_slots #(
    .ID_W          (ID_W),
    .ADDR_W        (ADDR_W),
    .PROC_QUANTITY (PROC_QUANTITY)
  ) i_thrd_cmd_slots (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid_i),
    .thrd_cmd_i   (thrd_cmd_i),
    .thrd_id_i    (thrd_id_i),
    .thrd_addr_i  (thrd_addr_i),
    .run_taken_i  (run_taken),
    .stop_clear_i (stop_clear),
    .scan_idx_i   (scan_idx),
    .run_pend_o   (run_pend),
    .run_id_o     (run_id),
    .run_addr_o   (run_addr),
    .stop_pend_o  (stop_pend),
    .stop_id_o    (stop_id),
    .stop_addr_o  (stop_addr),
    .stop_mark_o  (stop_mark),
    .cmd_done_o   (cmd_done_o),
    .cmd_ok_o     (cmd_ok_o)
  );

  thrd_table #(
    .ID_W          (ID_W),
    .ADDR_W        (ADDR_W),
    .PROC_QUANTITY (PROC_QUANTITY)
  ) i_thrd_table (
    .clk            (clk),
    .rd_addr_i      (rd_addr),
    .rd_id_o        (rd_id),
    .rd_addr_data_o (rd_addr_data),
    .wr_en_i        (wr_en),
    .wr_addr_i      (wr_addr),
    .wr_id_i        (wr_id),
    .wr_addr_data_i (wr_addr_data)
  );

  thrd_sched #(
    .ID_W          (ID_W),
    .ADDR_W        (ADDR_W),
    .PROC_QUANTITY (PROC_QUANTITY)
  ) i_thrd_sched (
    .clk                (clk),
    .rst                (rst),
    .next_thread_i      (next_thread_i),
    .run_pend_i         (run_pend),
    .run_id_i           (run_id),
    .run_addr_i         (run_addr),
    .stop_pend_i        (stop_pend),
    .stop_id_i          (stop_id),
    .stop_addr_i        (stop_addr),
    .stop_mark_i        (stop_mark),
    .run_taken_o        (run_taken),
    .stop_clear_o       (stop_clear),
    .scan_idx_o         (scan_idx),
    .tbl_rd_addr_o      (rd_addr),
    .tbl_rd_id_i        (rd_id),
    .tbl_rd_addr_data_i (rd_addr_data),
    .tbl_wr_en_o        (wr_en),
    .tbl_wr_addr_o      (wr_addr),
    .tbl_wr_id_o        (wr_id),
    .tbl_wr_addr_data_o (wr_addr_data),
    .next_valid_o       (next_valid_o),
    .stop_done_o        (stop_done_o),
    .next_id_o          (next_id_o),
    .next_addr_o        (next_addr_o),
    .count_o            (count_o)
  );

endmodule

// ==== threads_manager.f ====
source/thrd_pkg.sv
source/thrd_cmd_slots.sv
source/thrd_table.sv
source/thrd_sched.sv
source/threads_manager.sv
dv/tb_clk_gen.sv
dv/threads_manager_sva.sv
dv/threads_manager_tb.sv
